//--- pe_defines.svh
`ifndef PE_DEFINES_SVH
`define PE_DEFINES_SVH

// data word width
`define PE_WORD_W 8

// row and column width
`define PE_COORD_W 8

// feature values per beat
`define PE_LANES 4

// weight slots, same as window depth
`define PE_SLOTS 4

// fraction bits of the fixed-point format
`define PE_FRAC_BITS 4

// frame length and beat counter width
`define PE_LEN_W 16

// channel tag width
`define PE_CHAN_W 16

`endif

//--- pe_pkg.sv
`include "pe_defines.svh"

package pe_pkg;

    // signed fixed-point data word
    typedef logic signed [`PE_WORD_W-1:0] pe_word_t;

    // signed row or column coordinate
    typedef logic signed [`PE_COORD_W-1:0] pe_coord_t;

    // one feature group, lane 0 in the low bits
    typedef pe_word_t [`PE_LANES-1:0] pe_word_vec_t;

    typedef pe_coord_t [`PE_LANES-1:0] pe_coord_vec_t;

    // grids indexed [slot][lane]
    typedef pe_word_vec_t [`PE_SLOTS-1:0] pe_word_grid_t;

    typedef pe_coord_vec_t [`PE_SLOTS-1:0] pe_coord_grid_t;

    // frame progress
    typedef enum logic [1:0] {
        PE_IDLE,
        PE_LOAD_WEIGHT,
        PE_LOAD_FEATURE
    } pe_state_e;

endpackage

//--- pe_input_stage.sv
`timescale 1ns/100ps

`include "pe_defines.svh"

module pe_input_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  pe_pkg::pe_word_t      weight_value,
    input  pe_pkg::pe_coord_t     weight_row,
    input  pe_pkg::pe_coord_t     weight_col,
    input  pe_pkg::pe_word_vec_t  feature_value,
    input  pe_pkg::pe_coord_vec_t feature_row,
    input  pe_pkg::pe_coord_vec_t feature_col,
    input  logic [`PE_CHAN_W-1:0] in_channel,
    input  logic [`PE_LEN_W-1:0]  frame_len,
    output logic                  stage_valid,
    output logic                  frame_start,
    output logic                  weight_load,
    output logic [1:0]            weight_slot,
    output logic                  emit,
    output pe_pkg::pe_word_t      stage_weight_value,
    output pe_pkg::pe_coord_t     stage_weight_row,
    output pe_pkg::pe_coord_t     stage_weight_col,
    output pe_pkg::pe_word_vec_t  stage_feature_value,
    output pe_pkg::pe_coord_vec_t stage_feature_row,
    output pe_pkg::pe_coord_vec_t stage_feature_col,
    output logic [`PE_CHAN_W-1:0] stage_channel
);

    import pe_pkg::*;

    pe_state_e             state;
    pe_state_e             next_state;
    logic [`PE_LEN_W-1:0]  beat_cnt;
    logic [`PE_LEN_W-1:0]  len_q;
    logic [`PE_LEN_W-1:0]  beat_idx;
    logic [`PE_LEN_W-1:0]  cur_len;
    logic                  last_beat;
    logic                  emit_beat;

    // a beat seen in idle is beat 0 of a new frame
    always_comb begin
        if (state == PE_IDLE) begin
            beat_idx = '0;
            cur_len  = frame_len;
        end else begin
            beat_idx = beat_cnt;
            cur_len  = len_q;
        end
        last_beat = (beat_idx == cur_len - 1'b1);
        emit_beat = (beat_idx >= `PE_LEN_W'(`PE_SLOTS - 1));

        next_state = state;
        if (in_valid) begin
            if (last_beat) begin
                next_state = PE_IDLE;
            end else if (state == PE_IDLE) begin
                next_state = PE_LOAD_WEIGHT;
            end else if (beat_idx == `PE_LEN_W'(`PE_SLOTS - 1)) begin
                next_state = PE_LOAD_FEATURE;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= PE_IDLE;
            beat_cnt <= '0;
            len_q    <= '0;
        end else if (in_valid) begin
            state    <= next_state;
            beat_cnt <= last_beat ? '0 : beat_idx + 1'b1;
            if (state == PE_IDLE) begin
                len_q <= frame_len;
            end
        end
    end

    // control flags, one cycle after the beat
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_valid <= 1'b0;
            frame_start <= 1'b0;
            weight_load <= 1'b0;
            weight_slot <= '0;
            emit        <= 1'b0;
        end else begin
            stage_valid <= in_valid;
            frame_start <= in_valid && (state == PE_IDLE);
            weight_load <= in_valid && (state != PE_LOAD_FEATURE);
            emit        <= in_valid && emit_beat;
            if (in_valid) begin
                weight_slot <= beat_idx[1:0];
            end
        end
    end

    // beat data
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_weight_value  <= '0;
            stage_weight_row    <= '0;
            stage_weight_col    <= '0;
            stage_feature_value <= '0;
            stage_feature_row   <= '0;
            stage_feature_col   <= '0;
            stage_channel       <= '0;
        end else if (in_valid) begin
            stage_weight_value  <= weight_value;
            stage_weight_row    <= weight_row;
            stage_weight_col    <= weight_col;
            stage_feature_value <= feature_value;
            stage_feature_row   <= feature_row;
            stage_feature_col   <= feature_col;
            stage_channel       <= in_channel;
        end
    end

endmodule

//--- pe_operand_buffer.sv
`timescale 1ns/100ps

`include "pe_defines.svh"

module pe_operand_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stage_valid,
    input  logic                   frame_start,
    input  logic                   weight_load,
    input  logic [1:0]             weight_slot,
    input  logic                   emit,
    input  pe_pkg::pe_word_t       stage_weight_value,
    input  pe_pkg::pe_coord_t      stage_weight_row,
    input  pe_pkg::pe_coord_t      stage_weight_col,
    input  pe_pkg::pe_word_vec_t   stage_feature_value,
    input  pe_pkg::pe_coord_vec_t  stage_feature_row,
    input  pe_pkg::pe_coord_vec_t  stage_feature_col,
    input  logic [`PE_CHAN_W-1:0]  stage_channel,
    output logic                   win_valid,
    output pe_pkg::pe_word_vec_t   weights,
    output pe_pkg::pe_coord_vec_t  weight_rows,
    output pe_pkg::pe_coord_vec_t  weight_cols,
    output pe_pkg::pe_word_grid_t  window_value,
    output pe_pkg::pe_coord_grid_t window_row,
    output pe_pkg::pe_coord_grid_t window_col,
    output logic [`PE_CHAN_W-1:0]  win_channel
);

    // weight slots
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            weights     <= '0;
            weight_rows <= '0;
            weight_cols <= '0;
        end else if (stage_valid && weight_load) begin
            weights[weight_slot]     <= stage_weight_value;
            weight_rows[weight_slot] <= stage_weight_row;
            weight_cols[weight_slot] <= stage_weight_col;
        end
    end

    // group 0 takes the newest beat, older groups move up one
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            window_value <= '0;
            window_row   <= '0;
            window_col   <= '0;
        end else if (stage_valid) begin
            window_value[0] <= stage_feature_value;
            window_row[0]   <= stage_feature_row;
            window_col[0]   <= stage_feature_col;
            for (int k = 1; k < `PE_SLOTS; k++) begin
                // a new frame drops whatever the last one left behind
                window_value[k] <= frame_start ? '0 : window_value[k-1];
                window_row[k]   <= frame_start ? '0 : window_row[k-1];
                window_col[k]   <= frame_start ? '0 : window_col[k-1];
            end
        end
    end

    // lined up with the updated window
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            win_valid   <= 1'b0;
            win_channel <= '0;
        end else begin
            win_valid <= stage_valid && emit;
            if (stage_valid) begin
                win_channel <= stage_channel;
            end
        end
    end

endmodule

//--- pe_product_array.sv
`timescale 1ns/100ps

`include "pe_defines.svh"

module pe_product_array (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   win_valid,
    input  pe_pkg::pe_word_vec_t   weights,
    input  pe_pkg::pe_coord_vec_t  weight_rows,
    input  pe_pkg::pe_coord_vec_t  weight_cols,
    input  pe_pkg::pe_word_grid_t  window_value,
    input  pe_pkg::pe_coord_grid_t window_row,
    input  pe_pkg::pe_coord_grid_t window_col,
    input  logic [`PE_CHAN_W-1:0]  win_channel,
    output logic                   out_valid,
    output pe_pkg::pe_word_grid_t  data_out,
    output pe_pkg::pe_coord_grid_t data_out_row,
    output pe_pkg::pe_coord_grid_t data_out_col,
    output logic [`PE_CHAN_W-1:0]  out_channel
);

    import pe_pkg::*;

    pe_word_grid_t  prod_grid;
    pe_coord_grid_t row_grid;
    pe_coord_grid_t col_grid;

    // full signed product, then drop the extra fraction and integer bits
    function automatic pe_word_t mul_trunc(input pe_word_t a, input pe_word_t b);
        logic signed [2*`PE_WORD_W-1:0] full;
        full = a * b;
        return full[`PE_FRAC_BITS +: `PE_WORD_W];
    endfunction

    always_comb begin
        for (int i = 0; i < `PE_SLOTS; i++) begin
            for (int j = 0; j < `PE_LANES; j++) begin
                prod_grid[i][j] = mul_trunc(weights[i], window_value[i][j]);
                // offsets wrap to the coordinate width
                row_grid[i][j]  = window_row[i][j] - weight_rows[i];
                col_grid[i][j]  = window_col[i][j] - weight_cols[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid    <= 1'b0;
            data_out     <= '0;
            data_out_row <= '0;
            data_out_col <= '0;
            out_channel  <= '0;
        end else begin
            out_valid <= win_valid;
            if (win_valid) begin
                data_out     <= prod_grid;
                data_out_row <= row_grid;
                data_out_col <= col_grid;
                out_channel  <= win_channel;
            end else begin
                // grids read zero between outputs, channel holds
                data_out     <= '0;
                data_out_row <= '0;
                data_out_col <= '0;
            end
        end
    end

endmodule

//--- pe_unit.sv
`timescale 1ns/100ps

`include "pe_defines.svh"

module pe_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  pe_pkg::pe_word_t       weight_value,
    input  pe_pkg::pe_coord_t      weight_row,
    input  pe_pkg::pe_coord_t      weight_col,
    input  pe_pkg::pe_word_vec_t   feature_value,
    input  pe_pkg::pe_coord_vec_t  feature_row,
    input  pe_pkg::pe_coord_vec_t  feature_col,
    input  logic [`PE_CHAN_W-1:0]  in_channel,
    input  logic [`PE_LEN_W-1:0]   frame_len,
    output logic                   out_valid,
    output pe_pkg::pe_word_grid_t  data_out,
    output pe_pkg::pe_coord_grid_t data_out_row,
    output pe_pkg::pe_coord_grid_t data_out_col,
    output logic [`PE_CHAN_W-1:0]  out_channel
);

    import pe_pkg::*;

    // producer to buffer
    logic                  stage_valid;
    logic                  frame_start;
    logic                  weight_load;
    logic [1:0]            weight_slot;
    logic                  emit;
    pe_word_t              stage_weight_value;
    pe_coord_t             stage_weight_row;
    pe_coord_t             stage_weight_col;
    pe_word_vec_t          stage_feature_value;
    pe_coord_vec_t         stage_feature_row;
    pe_coord_vec_t         stage_feature_col;
    logic [`PE_CHAN_W-1:0] stage_channel;

    // buffer to consumer
    logic                  win_valid;
    pe_word_vec_t          weights;
    pe_coord_vec_t         weight_rows;
    pe_coord_vec_t         weight_cols;
    pe_word_grid_t         window_value;
    pe_coord_grid_t        window_row;
    pe_coord_grid_t        window_col;
    logic [`PE_CHAN_W-1:0] win_channel;

    pe_input_stage u_input_stage (
        .clk                 (clk),
        .rst                 (rst),
        .in_valid            (in_valid),
        .weight_value        (weight_value),
        .weight_row          (weight_row),
        .weight_col          (weight_col),
        .feature_value       (feature_value),
        .feature_row         (feature_row),
        .feature_col         (feature_col),
        .in_channel          (in_channel),
        .frame_len           (frame_len),
        .stage_valid         (stage_valid),
        .frame_start         (frame_start),
        .weight_load         (weight_load),
        .weight_slot         (weight_slot),
        .emit                (emit),
        .stage_weight_value  (stage_weight_value),
        .stage_weight_row    (stage_weight_row),
        .stage_weight_col    (stage_weight_col),
        .stage_feature_value (stage_feature_value),
        .stage_feature_row   (stage_feature_row),
        .stage_feature_col   (stage_feature_col),
        .stage_channel       (stage_channel)
    );

    pe_operand_buffer u_operand_buffer (
        .clk                 (clk),
        .rst                 (rst),
        .stage_valid         (stage_valid),
        .frame_start         (frame_start),
        .weight_load         (weight_load),
        .weight_slot         (weight_slot),
        .emit                (emit),
        .stage_weight_value  (stage_weight_value),
        .stage_weight_row    (stage_weight_row),
        .stage_weight_col    (stage_weight_col),
        .stage_feature_value (stage_feature_value),
        .stage_feature_row   (stage_feature_row),
        .stage_feature_col   (stage_feature_col),
        .stage_channel       (stage_channel),
        .win_valid           (win_valid),
        .weights             (weights),
        .weight_rows         (weight_rows),
        .weight_cols         (weight_cols),
        .window_value        (window_value),
        .window_row          (window_row),
        .window_col          (window_col),
        .win_channel         (win_channel)
    );

    pe_product_array u_product_array (
        .clk          (clk),
        .rst          (rst),
        .win_valid    (win_valid),
        .weights      (weights),
        .weight_rows  (weight_rows),
        .weight_cols  (weight_cols),
        .window_value (window_value),
        .window_row   (window_row),
        .window_col   (window_col),
        .win_channel  (win_channel),
        .out_valid    (out_valid),
        .data_out     (data_out),
        .data_out_row (data_out_row),
        .data_out_col (data_out_col),
        .out_channel  (out_channel)
    );

endmodule

//--- tb_pe_unit.sv
`timescale 1ns/100ps

`include "pe_defines.svh"

module tb_pe_unit;

    import pe_pkg::*;

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    pe_word_t              weight_value;
    pe_coord_t             weight_row;
    pe_coord_t             weight_col;
    pe_word_vec_t          feature_value;
    pe_coord_vec_t         feature_row;
    pe_coord_vec_t         feature_col;
    logic [`PE_CHAN_W-1:0] in_channel;
    logic [`PE_LEN_W-1:0]  frame_len;
    logic                  out_valid;
    pe_word_grid_t         data_out;
    pe_coord_grid_t        data_out_row;
    pe_coord_grid_t        data_out_col;
    logic [`PE_CHAN_W-1:0] out_channel;

    integer seed;
    int     edge_cnt = 0;
    int     last_edge = 0;
    int     err_total;
    int     err_test;
    int     outs_test;
    int     pushed_test;
    int     tests_run;
    int     tests_failed;
    string  cur_test;

    // current frame, kept so it can be replayed
    int                    beat_count;
    pe_word_t              f_weight [$];
    pe_coord_t             f_wrow [$];
    pe_coord_t             f_wcol [$];
    pe_word_vec_t          f_fval [$];
    pe_coord_vec_t         f_frow [$];
    pe_coord_vec_t         f_fcol [$];
    logic [`PE_CHAN_W-1:0] f_chan [$];

    // reference model state and expected outputs in beat order
    pe_word_vec_t          m_weights;
    pe_coord_vec_t         m_wrows;
    pe_coord_vec_t         m_wcols;
    pe_word_grid_t         m_win;
    pe_coord_grid_t        m_win_row;
    pe_coord_grid_t        m_win_col;
    pe_word_grid_t         exp_data_q [$];
    pe_coord_grid_t        exp_row_q [$];
    pe_coord_grid_t        exp_col_q [$];
    logic [`PE_CHAN_W-1:0] exp_chan_q [$];
    int                    exp_edge_q [$];

    pe_unit DUT (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // Q-format product, keep the word above the fraction bits
    function automatic pe_word_t fixed_mul(input pe_word_t a, input pe_word_t b);
        int          p;
        logic [31:0] s;
        p = int'(a) * int'(b);
        s = p >>> `PE_FRAC_BITS;
        return s[`PE_WORD_W-1:0];
    endfunction

    task automatic compare_word_grid(input string what, input pe_word_grid_t exp,
                                     input pe_word_grid_t act);
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
            err_test++;
        end
    endtask

    task automatic compare_coord_grid(input string what, input pe_coord_grid_t exp,
                                      input pe_coord_grid_t act);
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
            err_test++;
        end
    endtask

    task automatic compare_channel(input logic [`PE_CHAN_W-1:0] exp,
                                   input logic [`PE_CHAN_W-1:0] act);
        if (act !== exp) begin
            $display("Mismatch %s out_channel: expected %h actual %h", cur_test, exp, act);
            err_test++;
        end
    endtask

    always @(negedge clk) begin : output_monitor
        int exp_edge;
        if (!rst && out_valid) begin
            outs_test++;
            if (exp_data_q.size() == 0) begin
                $display("%s: out_valid went high with no beat waiting for it", cur_test);
                err_test++;
            end else begin
                exp_edge = exp_edge_q.pop_front();
                if (exp_edge != edge_cnt) begin
                    $display("Mismatch %s latency edge: expected %0d actual %0d",
                             cur_test, exp_edge, edge_cnt);
                    err_test++;
                end
                compare_word_grid("data_out", exp_data_q.pop_front(), data_out);
                compare_coord_grid("data_out_row", exp_row_q.pop_front(), data_out_row);
                compare_coord_grid("data_out_col", exp_col_q.pop_front(), data_out_col);
                compare_channel(exp_chan_q.pop_front(), out_channel);
            end
        end else if (!rst && (data_out != '0 || data_out_row != '0 || data_out_col != '0)) begin
            $display("%s: output grids are not zero while out_valid is low", cur_test);
            err_test++;
        end
    end

    task automatic make_frame(input int len);
        logic [31:0] r;
        beat_count = len;
        f_weight.delete();
        f_wrow.delete();
        f_wcol.delete();
        f_fval.delete();
        f_frow.delete();
        f_fcol.delete();
        f_chan.delete();
        repeat (len) begin
            r = rand32();
            f_weight.push_back(r[7:0]);
            f_wrow.push_back(r[15:8]);
            f_wcol.push_back(r[23:16]);
            f_fval.push_back(rand32());
            f_frow.push_back(rand32());
            f_fcol.push_back(rand32());
            r = rand32();
            f_chan.push_back(r[15:0]);
        end
    endtask

    task automatic idle_cycle();
        logic [31:0] r;
        r             = rand32();
        in_valid      = 1'b0;
        weight_value  = r[7:0];
        weight_row    = r[15:8];
        weight_col    = r[23:16];
        feature_value = rand32();
        feature_row   = rand32();
        feature_col   = rand32();
        in_channel    = r[31:16];
        @(posedge clk);
        #2;
    endtask

    task automatic drive_beat(input int b);
        pe_word_grid_t  e_data;
        pe_coord_grid_t e_row;
        pe_coord_grid_t e_col;
        logic [1:0]     slot;
        slot          = b[1:0];
        in_valid      = 1'b1;
        weight_value  = f_weight[b];
        weight_row    = f_wrow[b];
        weight_col    = f_wcol[b];
        feature_value = f_fval[b];
        feature_row   = f_frow[b];
        feature_col   = f_fcol[b];
        in_channel    = f_chan[b];
        // length only counts on beat 0
        frame_len     = (b == 0) ? `PE_LEN_W'(beat_count) : `PE_LEN_W'(rand32());
        // window shifts, a new frame starts it empty
        for (int k = `PE_SLOTS - 1; k > 0; k--) begin
            m_win[k]     = (b == 0) ? '0 : m_win[k-1];
            m_win_row[k] = (b == 0) ? '0 : m_win_row[k-1];
            m_win_col[k] = (b == 0) ? '0 : m_win_col[k-1];
        end
        m_win[0]     = f_fval[b];
        m_win_row[0] = f_frow[b];
        m_win_col[0] = f_fcol[b];
        if (b < `PE_SLOTS) begin
            m_weights[slot] = f_weight[b];
            m_wrows[slot]   = f_wrow[b];
            m_wcols[slot]   = f_wcol[b];
        end
        if (b >= `PE_SLOTS - 1) begin
            for (int i = 0; i < `PE_SLOTS; i++) begin
                for (int j = 0; j < `PE_LANES; j++) begin
                    e_data[i][j] = fixed_mul(m_weights[i], m_win[i][j]);
                    e_row[i][j]  = m_win_row[i][j] - m_wrows[i];
                    e_col[i][j]  = m_win_col[i][j] - m_wcols[i];
                end
            end
            exp_data_q.push_back(e_data);
            exp_row_q.push_back(e_row);
            exp_col_q.push_back(e_col);
            exp_chan_q.push_back(f_chan[b]);
            // sampled on the next edge, visible after two more
            exp_edge_q.push_back(edge_cnt + 3);
            pushed_test++;
        end
        last_edge = edge_cnt;
        @(posedge clk);
        #2;
    endtask

    task automatic send_frame(input int gap_pct);
        logic [31:0] r;
        for (int b = 0; b < beat_count; b++) begin
            r = rand32();
            if ((r % 100) < gap_pct) begin
                repeat (r[9:8] + 1) idle_cycle();
            end
            drive_beat(b);
        end
        in_valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        err_test    = 0;
        outs_test   = 0;
        pushed_test = 0;
    endtask

    task automatic end_test();
        int waited;
        waited = 0;
        // last beat must also be past the pipeline, so a stray pulse gets counted
        while ((exp_data_q.size() != 0 || edge_cnt <= last_edge + 3) && waited < 20) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (exp_data_q.size() != 0) begin
            $display("%s: timed out waiting for out_valid, %0d outputs never came",
                     cur_test, exp_data_q.size());
            err_test++;
            exp_data_q.delete();
            exp_row_q.delete();
            exp_col_q.delete();
            exp_chan_q.delete();
            exp_edge_q.delete();
        end
        if (outs_test != pushed_test) begin
            $display("Mismatch %s output count: expected %0d actual %0d",
                     cur_test, pushed_test, outs_test);
            err_test++;
        end
        tests_run++;
        if (err_test == 0) begin
            $display("test %s: pass, %0d outputs checked", cur_test, outs_test);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", cur_test, err_test);
        end
        err_total += err_test;
    endtask

    initial begin
        logic [31:0] r;
        seed          = 32'h9623_86e1;
        err_total     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        m_weights     = '0;
        m_wrows       = '0;
        m_wcols       = '0;
        m_win         = '0;
        m_win_row     = '0;
        m_win_col     = '0;
        rst           = 1'b1;
        in_valid      = 1'b0;
        weight_value  = '0;
        weight_row    = '0;
        weight_col    = '0;
        feature_value = '0;
        feature_row   = '0;
        feature_col   = '0;
        in_channel    = '0;
        frame_len     = `PE_LEN_W'(4);
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        start_test("reset_and_dense_frame");
        if (out_valid !== 1'b0) begin
            $display("%s: out_valid is not low after reset", cur_test);
            err_test++;
        end
        make_frame(8);
        send_frame(0);
        end_test();

        // same beats again, with idle cycles in between
        start_test("gapped_replay");
        send_frame(40);
        end_test();

        start_test("back_to_back_frames");
        make_frame(5);
        send_frame(0);
        make_frame(9);
        send_frame(0);
        make_frame(4);
        send_frame(0);
        end_test();

        start_test("random_frames");
        repeat (25) begin
            r = rand32();
            make_frame(4 + (r % 9));
            send_frame(30);
        end
        end_test();

        $display("tests run %0d, failed %0d, total errors %0d",
                 tests_run, tests_failed, err_total);
        if (err_total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
pe_pkg.sv
pe_input_stage.sv
pe_operand_buffer.sv
pe_product_array.sv
pe_unit.sv
tb_pe_unit.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_pe_unit -o tb_pe_unit
./obj_dir/tb_pe_unit | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
